/* source/pipe_trace_pkg.sv */
// pipeline trace types: cpu stage observations and the finished trace record
`default_nettype none

package pipe_trace_pkg;

    ////////////////////
    // basic words
    ////////////////////

    // data or address word of the traced cpu
    typedef logic [31:0] xlen_t;

    // free running cycle stamp
    typedef logic [31:0] cycle_t;

    // instruction sequence number, wraps
    typedef logic [15:0] seq_t;

    ////////////////////
    // cpu side observations
    ////////////////////

    // instruction fetched this cycle
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        xlen_t instr;
    } fetch_obs_t;

    // per stage results, each one belongs to the instruction now in that stage
    typedef struct packed {
        xlen_t alu_result;
        xlen_t mem_addr;
        xlen_t wb_data;
    } stage_obs_t;

    // hazard controls, flush has priority
    typedef struct packed {
        logic stall;
        logic flush;
    } pipe_ctrl_t;

    ////////////////////
    // trace record
    ////////////////////

    // one retired instruction, 240 bits
    typedef struct packed {
        seq_t   seq;
        xlen_t  pc;
        xlen_t  instr;
        cycle_t fetch_cycle;
        xlen_t  alu_result;
        xlen_t  mem_addr;
        xlen_t  wb_data;
        cycle_t done_cycle;
    } trace_rec_t;

endpackage

`default_nettype wire

/* source/apb_pkg.sv */
// apb request and response structs plus the trace reader register map
`default_nettype none

package apb_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // master to slave
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // slave to master
    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    ////////////////////
    // register map
    ////////////////////

    // status: level in [15:0], drops in [31:16]
    localparam apb_addr_t reg_status      = 8'h00;
    // fields of the fifo head
    localparam apb_addr_t reg_seq         = 8'h04;
    localparam apb_addr_t reg_pc          = 8'h08;
    localparam apb_addr_t reg_instr       = 8'h0c;
    localparam apb_addr_t reg_fetch_cycle = 8'h10;
    localparam apb_addr_t reg_alu         = 8'h14;
    localparam apb_addr_t reg_mem_addr    = 8'h18;
    localparam apb_addr_t reg_wb_data     = 8'h1c;
    localparam apb_addr_t reg_done_cycle  = 8'h20;
    // write only, any write pops the head
    localparam apb_addr_t reg_pop         = 8'h24;

endpackage

`default_nettype wire

/* source/pipe_trace_tracker.sv */
// follows each fetched instruction through a shadow five-stage pipeline and emits trace records
`default_nettype none

module pipe_trace_tracker (
    input  logic                       clk,
    input  logic                       rst,
    input  pipe_trace_pkg::fetch_obs_t fetch,
    input  pipe_trace_pkg::stage_obs_t stages,
    input  pipe_trace_pkg::pipe_ctrl_t ctrl,
    output logic                       push,
    output pipe_trace_pkg::trace_rec_t rec
);
    import pipe_trace_pkg::*;

    // slot indices of the shadow pipeline
    localparam int slot_if  = 0;
    localparam int slot_id  = 1;
    localparam int slot_ex  = 2;
    localparam int slot_mem = 3;
    localparam int slot_wb  = 4;

    logic [4:0] slot_v;
    trace_rec_t slot_r [0:4];

    cycle_t cycle_cnt;
    seq_t   seq_cnt;

    // front end moves only with neither stall nor flush
    logic advance;

    // records as they leave each slot, with that stage's field filled in
    trace_rec_t fetch_rec;
    trace_rec_t ex_out;
    trace_rec_t mem_out;
    trace_rec_t wb_out;

    assign advance = !ctrl.stall && !ctrl.flush;

    ////////////////////
    // record assembly
    ////////////////////

    always_comb begin
        // new entry, later stage fields filled on the way down
        fetch_rec             = '0;
        fetch_rec.seq         = seq_cnt;
        fetch_rec.pc          = fetch.pc;
        fetch_rec.instr       = fetch.instr;
        fetch_rec.fetch_cycle = cycle_cnt;

        // alu result belongs to whatever sits in ex right now
        ex_out            = slot_r[slot_ex];
        ex_out.alu_result = stages.alu_result;

        mem_out          = slot_r[slot_mem];
        mem_out.mem_addr = stages.mem_addr;

        // completion stamped on the edge that leaves wb
        wb_out            = slot_r[slot_wb];
        wb_out.wb_data    = stages.wb_data;
        wb_out.done_cycle = cycle_cnt;
    end

    ////////////////////
    // control state
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_v    <= '0;
            cycle_cnt <= '0;
            seq_cnt   <= '0;
            push      <= 1'b0;
        end else begin
            // counts every edge, hazards included
            cycle_cnt <= cycle_cnt + 1'b1;

            // back end always drains
            push            <= slot_v[slot_wb];
            slot_v[slot_wb]  <= slot_v[slot_mem];
            slot_v[slot_mem] <= slot_v[slot_ex];

            if (ctrl.flush) begin
                // wrong path instructions vanish, their seq numbers stay used
                slot_v[slot_ex] <= 1'b0;
                slot_v[slot_id] <= 1'b0;
                slot_v[slot_if] <= 1'b0;
            end else if (ctrl.stall) begin
                // if and id hold, bubble into ex
                slot_v[slot_ex] <= 1'b0;
            end else begin
                slot_v[slot_ex] <= slot_v[slot_id];
                slot_v[slot_id] <= slot_v[slot_if];
                slot_v[slot_if] <= fetch.valid;
                if (fetch.valid) begin
                    seq_cnt <= seq_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // payload
    ////////////////////

    // contents qualified by slot_v and push
    always_ff @(posedge clk) begin
        rec               <= wb_out;
        slot_r[slot_wb]   <= mem_out;
        slot_r[slot_mem]  <= ex_out;
        if (advance) begin
            slot_r[slot_ex] <= slot_r[slot_id];
            slot_r[slot_id] <= slot_r[slot_if];
            slot_r[slot_if] <= fetch_rec;
        end
    end

    // a record only comes out of an occupied wb slot, at least five edges after its fetch
    a_push_from_wb: assert property (
        @(posedge clk) disable iff (rst)
        push |-> ($past(slot_v[slot_wb]) && ((rec.done_cycle - rec.fetch_cycle) >= 32'd5))
    ) else $error("push without a valid wb slot");

    // stamps stay true cycle counts through hazards
    a_cycle_runs: assert property (
        @(posedge clk) disable iff (rst)
        (ctrl.stall || ctrl.flush) |=> (cycle_cnt == $past(cycle_cnt) + 1)
    ) else $error("cycle counter froze on stall or flush");

endmodule

`default_nettype wire

/* source/trace_fifo.sv */
// show-ahead ring buffer of trace records with fill level and overflow drop count
`default_nettype none

module trace_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            push,
    input  pipe_trace_pkg::trace_rec_t      rec,
    input  logic                            pop,
    output pipe_trace_pkg::trace_rec_t      head,
    output logic [$clog2(DEPTH+1)-1:0]      level,
    output logic [15:0]                     drops
);
    import pipe_trace_pkg::*;

    // pointer and level widths
    localparam int AW = $clog2(DEPTH);
    localparam int LW = $clog2(DEPTH + 1);

    trace_rec_t mem [0:DEPTH-1];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    logic full;
    // push lands when there is room, or a pop frees a slot on this edge
    logic wr_en;

    assign full  = (level == LW'(DEPTH));
    assign wr_en = push && (!full || pop);

    // head visible without a read strobe
    assign head = mem[rd_ptr];

    ////////////////////
    // pointers and counts
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
            drops  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // pop already checked against level upstream
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({wr_en, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase

            // lost record, count saturates
            if (push && !wr_en && drops != 16'hffff) begin
                drops <= drops + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= rec;
        end
    end

    // reader must never pop an empty buffer
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> (level != '0)
    ) else $error("pop while fifo empty");

    a_level_bound: assert property (
        @(posedge clk) disable iff (rst)
        level <= LW'(DEPTH)
    ) else $error("fifo level above depth");

endmodule

`default_nettype wire

/* source/trace_apb_reader.sv */
// apb slave that exposes the trace fifo head and status and pops the head on command
`default_nettype none

module trace_apb_reader #(
    parameter int DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  apb_pkg::apb_req_t           apb_req,
    output apb_pkg::apb_rsp_t           apb_rsp,
    input  pipe_trace_pkg::trace_rec_t  head,
    input  logic [$clog2(DEPTH+1)-1:0]  level,
    input  logic [15:0]                 drops,
    output logic                        pop
);
    import apb_pkg::*;
    import pipe_trace_pkg::*;

    // second cycle of a transfer, no wait states
    logic access;
    logic addr_hit;
    logic is_pop;
    logic empty;
    logic err;

    xlen_t rd_data;

    assign access = apb_req.psel && apb_req.penable;
    assign is_pop = (apb_req.paddr == reg_pop);
    assign empty  = (level == '0);

    ////////////////////
    // read decode
    ////////////////////

    always_comb begin
        rd_data  = '0;
        addr_hit = 1'b1;
        case (apb_req.paddr)
            reg_status:      rd_data = {drops, 16'(level)};
            reg_seq:         rd_data = 32'(head.seq);
            reg_pc:          rd_data = head.pc;
            reg_instr:       rd_data = head.instr;
            reg_fetch_cycle: rd_data = head.fetch_cycle;
            reg_alu:         rd_data = head.alu_result;
            reg_mem_addr:    rd_data = head.mem_addr;
            reg_wb_data:     rd_data = head.wb_data;
            reg_done_cycle:  rd_data = head.done_cycle;
            // write only, reads back zero
            reg_pop:         rd_data = '0;
            default:         addr_hit = 1'b0;
        endcase
    end

    // errors:
    // unmapped address
    // write to a read register
    // pop with nothing stored
    assign err = !addr_hit
               || (apb_req.pwrite && !is_pop)
               || (is_pop && apb_req.pwrite && empty);

    // single cycle strobe, takes effect at the edge closing the access phase
    assign pop = access && apb_req.pwrite && is_pop && !empty;

    ////////////////////
    // response
    ////////////////////

    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && err;
        apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_data : '0;
    end

    // protocol check on the master side
    a_penable_with_psel: assert property (
        @(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel
    ) else $error("penable without psel");

endmodule

`default_nettype wire

/* source/pipe_trace_top.sv */
// pipeline trace unit top: tracker feeds the trace fifo, apb reader drains it
`default_nettype none

module pipe_trace_top #(
    parameter int DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  pipe_trace_pkg::fetch_obs_t fetch,
    input  pipe_trace_pkg::stage_obs_t stages,
    input  pipe_trace_pkg::pipe_ctrl_t ctrl,
    input  apb_pkg::apb_req_t          apb_req,
    output apb_pkg::apb_rsp_t          apb_rsp
);
    import pipe_trace_pkg::*;

    // tracker to fifo
    logic       push;
    trace_rec_t rec;

    // fifo to reader
    trace_rec_t                   head;
    logic [$clog2(DEPTH+1)-1:0]   level;
    logic [15:0]                  drops;
    logic                         pop;

    // producer, never stalls the cpu
    pipe_trace_tracker u_tracker (
        .clk    (clk),
        .rst    (rst),
        .fetch  (fetch),
        .stages (stages),
        .ctrl   (ctrl),
        .push   (push),
        .rec    (rec)
    );

    // buffer, drops on overflow
    trace_fifo #(
        .DEPTH (DEPTH)
    ) u_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (push),
        .rec   (rec),
        .pop   (pop),
        .head  (head),
        .level (level),
        .drops (drops)
    );

    // consumer on the debug bus
    trace_apb_reader #(
        .DEPTH (DEPTH)
    ) u_reader (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .head    (head),
        .level   (level),
        .drops   (drops),
        .pop     (pop)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// clock and reset source for the trace unit testbench
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    // period 100
    localparam int half_period = 50;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // reset held for two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/pipe_trace_tb.sv */
// directed testbench for the pipeline trace unit, with a shadow pipeline model and apb master
`default_nettype none

module pipe_trace_tb;
    import pipe_trace_pkg::*;
    import apb_pkg::*;

    localparam int fifo_depth = 8;

    ////////////////////
    // run length
    ////////////////////

    // idle steps after the last fetch until the fifo holds everything
    localparam int drain_cycles = 8;
    // status read, eight field reads and a pop, two cycles each
    localparam int rec_cycles   = 20;
    localparam int len_flow     = 4 + drain_cycles + 4 * rec_cycles;
    localparam int len_stall    = 6 + drain_cycles + 3 * rec_cycles;
    localparam int len_flush    = 5 + drain_cycles + 2 * rec_cycles;
    localparam int len_overflow = fifo_depth + 3 + drain_cycles + 4 + fifo_depth * rec_cycles;
    localparam int len_errors   = 1 + drain_cycles + 7 * 2 + rec_cycles;
    localparam int max_cycles   =
        2 * (4 + len_flow + len_stall + len_flush + len_overflow + len_errors);

    logic       clk;
    logic       rst;
    fetch_obs_t fetch;
    stage_obs_t stages;
    pipe_ctrl_t ctrl;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;

    // shadow pipeline, index into tab or -1 for an empty slot
    int         m_slot [0:4];
    trace_rec_t tab [0:63];
    int         tab_cnt;
    seq_t       tb_seq;
    cycle_t     tb_cycle;
    // expected fifo contents and overflow count
    trace_rec_t exp_q [$];
    int         exp_drops;
    int         run_cycles = 0;

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    pipe_trace_top #(
        .DEPTH (fifo_depth)
    ) UUT (
        .clk     (clk),
        .rst     (rst),
        .fetch   (fetch),
        .stages  (stages),
        .ctrl    (ctrl),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    ////////////////////
    // failure handling
    ////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    always @(posedge clk) begin
        run_cycles = run_cycles + 1;
        if (run_cycles >= max_cycles) begin
            abort_run($sformatf("timeout: run exceeded %0d cycles", max_cycles));
        end
    end

    task automatic check_word(input string name, input xlen_t exp, input xlen_t got);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s: expected %h, got %h", name, exp, got));
        end
    endtask

    task automatic check_rec(input trace_rec_t exp, input trace_rec_t got);
        check_word("seq", 32'(exp.seq), 32'(got.seq));
        check_word("pc", exp.pc, got.pc);
        check_word("instr", exp.instr, got.instr);
        check_word("fetch_cycle", exp.fetch_cycle, got.fetch_cycle);
        check_word("alu_result", exp.alu_result, got.alu_result);
        check_word("mem_addr", exp.mem_addr, got.mem_addr);
        check_word("wb_data", exp.wb_data, got.wb_data);
        check_word("done_cycle", exp.done_cycle, got.done_cycle);
    endtask

    // prdata only compared for reads that should succeed
    task automatic check_apb(input string name, input apb_data_t exp_data, input logic exp_err,
                             input logic check_data, input apb_rsp_t rsp);
        if (rsp.pslverr !== exp_err) begin
            abort_run($sformatf("FAIL %s pslverr: expected %h, got %h",
                                name, exp_err, rsp.pslverr));
        end
        if (check_data) begin
            check_word({name, " prdata"}, exp_data, rsp.prdata);
        end
    endtask

    ////////////////////
    // cpu side driver and model
    ////////////////////

    // stage rules applied to the shadow slots on one edge
    task automatic model_edge(input logic stall, input logic flush, input int new_idx);
        trace_rec_t done;
        if (m_slot[4] >= 0) begin
            done = tab[m_slot[4]];
            done.done_cycle = tb_cycle;
            if (exp_q.size() < fifo_depth) begin
                exp_q.push_back(done);
            end else begin
                exp_drops++;
            end
        end
        m_slot[4] = m_slot[3];
        m_slot[3] = m_slot[2];
        if (flush) begin
            m_slot[2] = -1;
            m_slot[1] = -1;
            m_slot[0] = -1;
        end else if (stall) begin
            m_slot[2] = -1;
        end else begin
            m_slot[2] = m_slot[1];
            m_slot[1] = m_slot[0];
            m_slot[0] = new_idx;
        end
        tb_cycle++;
    endtask

    // one clock of cpu activity, called right after a rising edge
    task automatic step_cpu(input logic fv, input logic stall, input logic flush);
        fetch_obs_t f;
        stage_obs_t s;
        pipe_ctrl_t c;
        int         new_idx;
        f.valid = fv;
        f.pc    = $urandom;
        f.instr = $urandom;
        new_idx = -1;
        // a fetch only counts when the front end moves
        if (fv && !stall && !flush) begin
            new_idx = tab_cnt;
            tab_cnt++;
            tab[new_idx]             = '0;
            tab[new_idx].seq         = tb_seq;
            tab[new_idx].pc          = f.pc;
            tab[new_idx].instr       = f.instr;
            tab[new_idx].fetch_cycle = tb_cycle;
            tab[new_idx].alu_result  = $urandom;
            tab[new_idx].mem_addr    = $urandom;
            tab[new_idx].wb_data     = $urandom;
            tb_seq++;
        end
        // stage values of whatever sits there, noise in empty stages
        s.alu_result = (m_slot[2] >= 0) ? tab[m_slot[2]].alu_result : xlen_t'($urandom);
        s.mem_addr   = (m_slot[3] >= 0) ? tab[m_slot[3]].mem_addr : xlen_t'($urandom);
        s.wb_data    = (m_slot[4] >= 0) ? tab[m_slot[4]].wb_data : xlen_t'($urandom);
        c.stall = stall;
        c.flush = flush;
        fetch  <= f;
        stages <= s;
        ctrl   <= c;
        @(posedge clk);
        model_edge(stall, flush, new_idx);
    endtask

    task automatic drain();
        repeat (drain_cycles) step_cpu(1'b0, 1'b0, 1'b0);
    endtask

    ////////////////////
    // apb master
    ////////////////////

    task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_rsp_t rsp);
        apb_req_t req;
        int       waits;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = write;
        req.paddr   = addr;
        req.pwdata  = wdata;
        apb_req <= req;
        step_cpu(1'b0, 1'b0, 1'b0);
        req.penable = 1'b1;
        apb_req <= req;
        step_cpu(1'b0, 1'b0, 1'b0);
        waits = 0;
        // response sampled at the edge closing the access phase
        while (!apb_rsp.pready) begin
            waits++;
            if (waits > 16) begin
                abort_run("apb slave never raised pready");
            end else begin
                step_cpu(1'b0, 1'b0, 1'b0);
            end
        end
        rsp = apb_rsp;
        apb_req <= '0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_rsp_t rsp);
        apb_transfer(1'b0, addr, '0, rsp);
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output apb_rsp_t rsp);
        apb_transfer(1'b1, addr, data, rsp);
    endtask

    // level and drops as the model predicts
    task automatic check_status();
        apb_rsp_t rsp;
        apb_read(reg_status, rsp);
        check_apb("status", {16'(exp_drops), 16'(exp_q.size())}, 1'b0, 1'b1, rsp);
    endtask

    task automatic read_field(input apb_addr_t addr, input string name, output xlen_t d);
        apb_rsp_t rsp;
        apb_read(addr, rsp);
        check_apb(name, '0, 1'b0, 1'b0, rsp);
        d = rsp.prdata;
    endtask

    task automatic read_head(output trace_rec_t r);
        xlen_t d;
        read_field(reg_seq, "seq read", d);
        r.seq = seq_t'(d);
        read_field(reg_pc, "pc read", r.pc);
        read_field(reg_instr, "instr read", r.instr);
        read_field(reg_fetch_cycle, "fetch_cycle read", r.fetch_cycle);
        read_field(reg_alu, "alu read", r.alu_result);
        read_field(reg_mem_addr, "mem_addr read", r.mem_addr);
        read_field(reg_wb_data, "wb_data read", r.wb_data);
        read_field(reg_done_cycle, "done_cycle read", r.done_cycle);
    endtask

    // status, full head compare, then pop
    task automatic pop_and_check(output trace_rec_t got);
        trace_rec_t exp;
        apb_rsp_t   rsp;
        if (exp_q.size() == 0) begin
            abort_run("no trace record expected but one was requested");
        end
        check_status();
        read_head(got);
        exp = exp_q.pop_front();
        check_rec(exp, got);
        apb_write(reg_pop, '0, rsp);
        check_apb("pop", '0, 1'b0, 1'b0, rsp);
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic test_straight_flow();
        trace_rec_t got;
        seq_t       first;
        int         i;
        repeat (4) step_cpu(1'b1, 1'b0, 1'b0);
        drain();
        for (i = 0; i < 4; i++) begin
            pop_and_check(got);
            if (i == 0) begin
                first = got.seq;
            end
            check_word("seq in order", 32'(seq_t'(first + i)), 32'(got.seq));
            check_word("done_cycle - fetch_cycle", 32'd5, got.done_cycle - got.fetch_cycle);
        end
    endtask

    task automatic test_stall();
        trace_rec_t got;
        seq_t       b_seq;
        step_cpu(1'b1, 1'b0, 1'b0);
        step_cpu(1'b1, 1'b0, 1'b0);
        // older one in id, fetch offered all through the stall
        repeat (3) step_cpu(1'b1, 1'b1, 1'b0);
        step_cpu(1'b1, 1'b0, 1'b0);
        drain();
        pop_and_check(got);
        check_word("stalled done_cycle - fetch_cycle", 32'd8, got.done_cycle - got.fetch_cycle);
        pop_and_check(got);
        b_seq = got.seq;
        pop_and_check(got);
        check_word("seq after stall", 32'(seq_t'(b_seq + 1)), 32'(got.seq));
    endtask

    task automatic test_flush();
        trace_rec_t got;
        seq_t       p_seq;
        repeat (3) step_cpu(1'b1, 1'b0, 1'b0);
        // second and third are in id and if here
        step_cpu(1'b1, 1'b0, 1'b1);
        step_cpu(1'b1, 1'b0, 1'b0);
        drain();
        pop_and_check(got);
        p_seq = got.seq;
        pop_and_check(got);
        check_word("seq after flush", 32'(seq_t'(p_seq + 3)), 32'(got.seq));
    endtask

    task automatic test_overflow();
        trace_rec_t got;
        apb_rsp_t   rsp;
        repeat (fifo_depth + 3) step_cpu(1'b1, 1'b0, 1'b0);
        drain();
        apb_read(reg_status, rsp);
        check_apb("full status", {16'd3, 16'(fifo_depth)}, 1'b0, 1'b1, rsp);
        repeat (fifo_depth) pop_and_check(got);
        check_status();
    endtask

    task automatic test_apb_errors();
        trace_rec_t got;
        apb_rsp_t   rsp;
        step_cpu(1'b1, 1'b0, 1'b0);
        drain();
        check_status();
        apb_read(8'h3c, rsp);
        check_apb("unmapped read", '0, 1'b1, 1'b0, rsp);
        check_status();
        apb_write(reg_pc, $urandom, rsp);
        check_apb("write to reg_pc", '0, 1'b1, 1'b0, rsp);
        check_status();
        pop_and_check(got);
        // now empty
        apb_write(reg_pop, '0, rsp);
        check_apb("pop of empty fifo", '0, 1'b1, 1'b0, rsp);
        check_status();
    endtask

    initial begin
        void'($urandom(32'h7805));
        fetch   = '0;
        stages  = '0;
        ctrl    = '0;
        apb_req = '0;
        for (int k = 0; k < 5; k++) begin
            m_slot[k] = -1;
        end
        tab_cnt   = 0;
        tb_seq    = '0;
        tb_cycle  = '0;
        exp_drops = 0;

        @(posedge clk);
        while (rst) @(posedge clk);
        // this first edge out of reset already counted
        tb_cycle = 1;

        test_straight_flow();
        test_stall();
        test_flush();
        test_overflow();
        test_apb_errors();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* pipe_trace.f */
source/pipe_trace_pkg.sv
source/apb_pkg.sv
source/pipe_trace_tracker.sv
source/trace_fifo.sv
source/trace_apb_reader.sv
source/pipe_trace_top.sv
testbench/tb_clock_gen.sv
testbench/pipe_trace_tb.sv

/* Bender.yml */
package:
  name: pipe_trace

sources:
  - files:
      - source/pipe_trace_pkg.sv
      - source/apb_pkg.sv
      - source/pipe_trace_tracker.sv
      - source/trace_fifo.sv
      - source/trace_apb_reader.sv
      - source/pipe_trace_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/pipe_trace_tb.sv
